// File: rtl/aes_bridge_pkg.sv
//--------------------------------------------------------------------
// shared widths, bus address, aes tables and bridge types
// imported by the loader, round engine, key schedule and read buffer
//--------------------------------------------------------------------
`default_nettype none

package aes_bridge_pkg;

	// widths that carry a meaning
	typedef logic [7:0]   byte_t;   // one byte of the serial data bus
	typedef logic [31:0]  word_t;   // host data and address word
	typedef logic [127:0] block_t;  // aes state, key or ciphertext
	typedef logic [3:0]   round_t;  // round counter

	localparam word_t  BRIDGE_DATA_ADDR = 32'h0000_0510; // the one decoded address
	localparam int     BLOCK_BYTES      = 16;            // bytes per aes block
	localparam round_t NUM_ROUNDS       = 4'd10;         // aes-128

	// first round constant, and the reduction byte for gf(2^8) doubling
	localparam byte_t RCON_INIT = 8'h01;
	localparam byte_t GF_POLY   = 8'h1b;   // x^8 = x^4 + x^3 + x + 1

	typedef enum logic [1:0] {
		LOAD_KEY,   // gathering key bytes
		LOAD_TEXT,  // gathering plaintext bytes
		BUSY        // block in flight or waiting to be read out
	} loader_state_t;

	// payload handed from loader to engine
	typedef struct packed {
		block_t key;
		block_t text;
	} aes_job_t;

	//----------------------------------------------------------------
	// forward s-box, two lines per table row
	//----------------------------------------------------------------
	localparam byte_t SBOX [256] = '{
		8'h63, 8'h7c, 8'h77, 8'h7b, 8'hf2, 8'h6b, 8'h6f, 8'hc5,
		8'h30, 8'h01, 8'h67, 8'h2b, 8'hfe, 8'hd7, 8'hab, 8'h76,
		8'hca, 8'h82, 8'hc9, 8'h7d, 8'hfa, 8'h59, 8'h47, 8'hf0,
		8'had, 8'hd4, 8'ha2, 8'haf, 8'h9c, 8'ha4, 8'h72, 8'hc0,
		8'hb7, 8'hfd, 8'h93, 8'h26, 8'h36, 8'h3f, 8'hf7, 8'hcc,
		8'h34, 8'ha5, 8'he5, 8'hf1, 8'h71, 8'hd8, 8'h31, 8'h15,
		8'h04, 8'hc7, 8'h23, 8'hc3, 8'h18, 8'h96, 8'h05, 8'h9a,
		8'h07, 8'h12, 8'h80, 8'he2, 8'heb, 8'h27, 8'hb2, 8'h75,
		8'h09, 8'h83, 8'h2c, 8'h1a, 8'h1b, 8'h6e, 8'h5a, 8'ha0,
		8'h52, 8'h3b, 8'hd6, 8'hb3, 8'h29, 8'he3, 8'h2f, 8'h84,
		8'h53, 8'hd1, 8'h00, 8'hed, 8'h20, 8'hfc, 8'hb1, 8'h5b,
		8'h6a, 8'hcb, 8'hbe, 8'h39, 8'h4a, 8'h4c, 8'h58, 8'hcf,
		8'hd0, 8'hef, 8'haa, 8'hfb, 8'h43, 8'h4d, 8'h33, 8'h85,
		8'h45, 8'hf9, 8'h02, 8'h7f, 8'h50, 8'h3c, 8'h9f, 8'ha8,
		8'h51, 8'ha3, 8'h40, 8'h8f, 8'h92, 8'h9d, 8'h38, 8'hf5,
		8'hbc, 8'hb6, 8'hda, 8'h21, 8'h10, 8'hff, 8'hf3, 8'hd2,
		8'hcd, 8'h0c, 8'h13, 8'hec, 8'h5f, 8'h97, 8'h44, 8'h17,
		8'hc4, 8'ha7, 8'h7e, 8'h3d, 8'h64, 8'h5d, 8'h19, 8'h73,
		8'h60, 8'h81, 8'h4f, 8'hdc, 8'h22, 8'h2a, 8'h90, 8'h88,
		8'h46, 8'hee, 8'hb8, 8'h14, 8'hde, 8'h5e, 8'h0b, 8'hdb,
		8'he0, 8'h32, 8'h3a, 8'h0a, 8'h49, 8'h06, 8'h24, 8'h5c,
		8'hc2, 8'hd3, 8'hac, 8'h62, 8'h91, 8'h95, 8'he4, 8'h79,
		8'he7, 8'hc8, 8'h37, 8'h6d, 8'h8d, 8'hd5, 8'h4e, 8'ha9,
		8'h6c, 8'h56, 8'hf4, 8'hea, 8'h65, 8'h7a, 8'hae, 8'h08,
		8'hba, 8'h78, 8'h25, 8'h2e, 8'h1c, 8'ha6, 8'hb4, 8'hc6,
		8'he8, 8'hdd, 8'h74, 8'h1f, 8'h4b, 8'hbd, 8'h8b, 8'h8a,
		8'h70, 8'h3e, 8'hb5, 8'h66, 8'h48, 8'h03, 8'hf6, 8'h0e,
		8'h61, 8'h35, 8'h57, 8'hb9, 8'h86, 8'hc1, 8'h1d, 8'h9e,
		8'he1, 8'hf8, 8'h98, 8'h11, 8'h69, 8'hd9, 8'h8e, 8'h94,
		8'h9b, 8'h1e, 8'h87, 8'he9, 8'hce, 8'h55, 8'h28, 8'hdf,
		8'h8c, 8'ha1, 8'h89, 8'h0d, 8'hbf, 8'he6, 8'h42, 8'h68,
		8'h41, 8'h99, 8'h2d, 8'h0f, 8'hb0, 8'h54, 8'hbb, 8'h16
	};

	// multiply by x in gf(2^8), shared by mixcolumns and the rcon update
	function automatic byte_t gf_xtime(input byte_t b);
		return {b[6:0], 1'b0} ^ (b[7] ? GF_POLY : 8'h00);
	endfunction

endpackage

`default_nettype wire

// File: rtl/aes_byte_loader.sv
//--------------------------------------------------------------------
// write side of the bridge
// takes the low byte of each write at the data address, builds key
// then plaintext, and launches one block per 32 accepted bytes
//--------------------------------------------------------------------
`default_nettype none

module aes_byte_loader
	import aes_bridge_pkg::*;
(
	input  wire         clk_main_a0,
	input  wire         rst_main_n_sync,
	input  wire         wready,          // write strobe, no back-pressure
	input  wire word_t  wr_addr,
	input  wire word_t  wdata,           // only [7:0] is taken
	input  wire         drained,         // last cipher byte read out
	output aes_job_t    job,
	output logic        start            // one cycle, after 32nd byte
);

	loader_state_t state_q;
	logic [3:0]    byte_cnt_q;   // bytes taken in the current half
	logic          wr_hit;       // write accepted this cycle
	logic          last_byte;    // 16th byte of key or text
	byte_t         wr_byte;

	// writes while busy simply fall on the floor
	assign wr_hit    = wready && (wr_addr == BRIDGE_DATA_ADDR) && (state_q != BUSY);
	assign last_byte = (byte_cnt_q == 4'(BLOCK_BYTES - 1));
	assign wr_byte   = wdata[7:0];

	//----------------------------------------------------------------
	// fsm and byte counter
	//----------------------------------------------------------------
	always_ff @(posedge clk_main_a0)
	begin
		if (!rst_main_n_sync)
		begin
			state_q    <= LOAD_KEY;
			byte_cnt_q <= '0;
			start      <= 1'b0;
		end
		else
		begin
			start <= 1'b0;   // pulse by default
			if (wr_hit)
				byte_cnt_q <= byte_cnt_q + 4'd1;   // wraps 15 -> 0 at each half
			case (state_q)
				LOAD_KEY:
				begin
					if (wr_hit && last_byte)
						state_q <= LOAD_TEXT;
				end
				LOAD_TEXT:
				begin
					if (wr_hit && last_byte)
					begin
						state_q <= BUSY;
						start   <= 1'b1;   // job complete next cycle
					end
				end
				BUSY:
				begin
					if (drained)
						state_q <= LOAD_KEY;   // re-arm for next key
				end
				default: state_q <= LOAD_KEY;
			endcase
		end
	end

	// byte shifters, first byte ends up most significant
	always_ff @(posedge clk_main_a0)
	begin
		if (wr_hit && (state_q == LOAD_KEY))
			job.key <= {job.key[119:0], wr_byte};
		if (wr_hit && (state_q == LOAD_TEXT))
			job.text <= {job.text[119:0], wr_byte};
	end

endmodule

`default_nettype wire

// File: rtl/aes_key_schedule.sv
//--------------------------------------------------------------------
// aes-128 key expansion step, purely combinational
// the round engine feeds in the current round key and rcon and
// registers the next pair once per round
//--------------------------------------------------------------------
`default_nettype none

module aes_key_schedule
	import aes_bridge_pkg::*;
(
	input  wire block_t round_key,        // key of the round just applied
	input  wire byte_t  rcon,             // rcon for the next key
	output block_t      next_round_key,
	output byte_t       next_rcon
);

	logic [31:0] w0, w1, w2, w3;   // current key words, w0 on top
	logic [31:0] rot_w;            // rotword(w3)
	logic [31:0] sub_w;            // subword(rotword(w3))
	logic [31:0] temp_w;
	logic [31:0] n0, n1, n2, n3;   // next key words

	assign w0 = round_key[127:96];
	assign w1 = round_key[95:64];
	assign w2 = round_key[63:32];
	assign w3 = round_key[31:0];

	assign rot_w = {w3[23:0], w3[31:24]};   // one byte left

	// s-box on each byte of the rotated word
	always_comb
	begin
		for (int i = 0; i < 4; i++)
		begin
			sub_w[8*i +: 8] = SBOX[rot_w[8*i +: 8]];
		end
	end

	assign temp_w = sub_w ^ {rcon, 24'h00_0000};   // rcon only hits top byte

	// chained xor across the four words
	assign n0 = w0 ^ temp_w;
	assign n1 = w1 ^ n0;
	assign n2 = w2 ^ n1;
	assign n3 = w3 ^ n2;

	assign next_round_key = {n0, n1, n2, n3};
	assign next_rcon      = gf_xtime(rcon);   // 01 02 04 .. 80 1b 36

endmodule

`default_nettype wire

// File: rtl/aes_round_engine.sv
//--------------------------------------------------------------------
// iterative aes-128 encryption, one full round per clock
// start loads text xor key, done rises 11 cycles later with the
// ciphertext on cipher; the round key is expanded alongside
//--------------------------------------------------------------------
`default_nettype none

module aes_round_engine
	import aes_bridge_pkg::*;
(
	input  wire           clk_main_a0,
	input  wire           rst_main_n_sync,
	input  wire aes_job_t job,
	input  wire           start,
	output block_t        cipher,   // valid while done is high
	output logic          done
);

	block_t state_q;          // aes state, byte 0 in [127:120]
	block_t round_key_q;      // key of the last applied round
	byte_t  rcon_q;
	round_t round_q;          // round being applied this cycle
	logic   active_q;
	block_t next_round_key;
	byte_t  next_rcon;
	block_t sub_out, shift_out, mix_out, round_out;

	//----------------------------------------------------------------
	// round transforms, state bytes are column major
	//----------------------------------------------------------------
	function automatic block_t sub_bytes(input block_t s);
		block_t r;
		for (int i = 0; i < 16; i++)
		begin
			r[127 - 8*i -: 8] = SBOX[s[127 - 8*i -: 8]];
		end
		return r;
	endfunction

	function automatic block_t shift_rows(input block_t s);
		block_t r;
		for (int c = 0; c < 4; c++)
		begin
			for (int row = 0; row < 4; row++)
			begin
				// row n rotates left by n columns
				r[127 - 8*(row + 4*c) -: 8] = s[127 - 8*(row + 4*((c + row) % 4)) -: 8];
			end
		end
		return r;
	endfunction

	function automatic block_t mix_columns(input block_t s);
		block_t r;
		byte_t  a0, a1, a2, a3;
		for (int c = 0; c < 4; c++)
		begin
			a0 = s[127 - 32*c -: 8];
			a1 = s[119 - 32*c -: 8];
			a2 = s[111 - 32*c -: 8];
			a3 = s[103 - 32*c -: 8];
			r[127 - 32*c -: 8] = gf_xtime(a0) ^ gf_xtime(a1) ^ a1 ^ a2 ^ a3;   // 2 3 1 1
			r[119 - 32*c -: 8] = a0 ^ gf_xtime(a1) ^ gf_xtime(a2) ^ a2 ^ a3;   // 1 2 3 1
			r[111 - 32*c -: 8] = a0 ^ a1 ^ gf_xtime(a2) ^ gf_xtime(a3) ^ a3;   // 1 1 2 3
			r[103 - 32*c -: 8] = gf_xtime(a0) ^ a0 ^ a1 ^ a2 ^ gf_xtime(a3);   // 3 1 1 2
		end
		return r;
	endfunction

	aes_key_schedule u_key_schedule (
		.round_key      (round_key_q),
		.rcon           (rcon_q),
		.next_round_key (next_round_key),
		.next_rcon      (next_rcon)
	);

	assign sub_out   = sub_bytes(state_q);
	assign shift_out = shift_rows(sub_out);
	assign mix_out   = mix_columns(shift_out);
	// last round has no mixcolumns
	assign round_out = ((round_q == NUM_ROUNDS) ? shift_out : mix_out) ^ next_round_key;
	assign cipher    = state_q;

	// round counter and done pulse
	always_ff @(posedge clk_main_a0)
	begin
		if (!rst_main_n_sync)
		begin
			active_q <= 1'b0;
			round_q  <= '0;
			done     <= 1'b0;
		end
		else
		begin
			done <= 1'b0;
			if (start)
			begin
				active_q <= 1'b1;
				round_q  <= 4'd1;
			end
			else if (active_q)
			begin
				if (round_q == NUM_ROUNDS)
				begin
					active_q <= 1'b0;
					done     <= 1'b1;   // final round lands with this edge
				end
				else
					round_q <= round_q + 4'd1;
			end
		end
	end

	// datapath registers
	always_ff @(posedge clk_main_a0)
	begin
		if (start)
		begin
			state_q     <= job.text ^ job.key;   // initial addroundkey
			round_key_q <= job.key;
			rcon_q      <= RCON_INIT;
		end
		else if (active_q)
		begin
			state_q     <= round_out;
			round_key_q <= next_round_key;
			rcon_q      <= next_rcon;
		end
	end

endmodule

`default_nettype wire

// File: rtl/aes_cipher_buffer.sv
//--------------------------------------------------------------------
// read side of the bridge
// holds one ciphertext block and hands it out a byte per read on the
// arvalid/rvalid/rready channel, then signals drained to re-arm
//--------------------------------------------------------------------
`default_nettype none

module aes_cipher_buffer
	import aes_bridge_pkg::*;
(
	input  wire         clk_main_a0,
	input  wire         rst_main_n_sync,
	input  wire block_t cipher,
	input  wire         done,        // cipher valid this cycle
	input  wire         arvalid_q,   // read request, one cycle
	input  wire word_t  araddr_q,
	input  wire         rready,
	output logic        rvalid,
	output word_t       rdata,
	output logic        drained      // cycle after 16th byte handshake
);

	block_t     buf_q;     // next byte always in [127:120]
	logic       full_q;    // ciphertext held
	logic [4:0] left_q;    // bytes still to hand out
	logic       hit_q;     // response in flight carries a cipher byte
	logic       rd_req;    // request taken this cycle
	logic       rd_data;   // ... and it hits held ciphertext
	logic       rd_done;   // handshake completes

	assign rd_req  = arvalid_q && !rvalid;   // ignored while a response waits
	assign rd_data = rd_req && full_q && (araddr_q == BRIDGE_DATA_ADDR);
	assign rd_done = rvalid && rready;

	//----------------------------------------------------------------
	// read channel and occupancy
	//----------------------------------------------------------------
	always_ff @(posedge clk_main_a0)
	begin
		if (!rst_main_n_sync)
		begin
			rvalid  <= 1'b0;
			rdata   <= '0;
			hit_q   <= 1'b0;
			full_q  <= 1'b0;
			left_q  <= '0;
			drained <= 1'b0;
		end
		else
		begin
			drained <= 1'b0;
			if (done)
			begin
				full_q <= 1'b1;
				left_q <= 5'(BLOCK_BYTES);
			end
			if (rd_req)
			begin
				rvalid <= 1'b1;
				hit_q  <= rd_data;
				rdata  <= rd_data ? {24'h00_0000, buf_q[127:120]} : '0;   // miss reads zero
			end
			else if (rd_done)
			begin
				rvalid <= 1'b0;
				hit_q  <= 1'b0;
				if (hit_q)
				begin
					left_q <= left_q - 5'd1;   // byte consumed only on handshake
					if (left_q == 5'd1)
					begin
						full_q  <= 1'b0;
						drained <= 1'b1;
					end
				end
			end
		end
	end

	// byte shifter
	always_ff @(posedge clk_main_a0)
	begin
		if (done)
			buf_q <= cipher;
		else if (rd_done && hit_q)
			buf_q <= {buf_q[119:0], 8'h00};
	end

endmodule

`default_nettype wire

// File: rtl/aes_fifo_bridge.sv
//--------------------------------------------------------------------
// top level of the register-mapped aes-128 bridge
// host writes key then plaintext bytes at the data address and reads
// the ciphertext back a byte at a time from the same address
//--------------------------------------------------------------------
`default_nettype none

module aes_fifo_bridge
	import aes_bridge_pkg::*;
(
	input  wire        clk_main_a0,
	input  wire        rst_main_n_sync,
	// write side
	input  wire        wready,
	input  wire word_t wr_addr,
	input  wire word_t wdata,
	// read channel
	input  wire        arvalid_q,
	input  wire word_t araddr_q,
	input  wire        rready,
	output logic       rvalid,
	output word_t      rdata
);

	aes_job_t job;       // key and plaintext, stable from start
	logic     start;     // loader launches a block
	block_t   cipher;
	logic     done;      // engine result valid
	logic     drained;   // buffer emptied, loader may take a new key

	// write path, 32 bytes in
	aes_byte_loader u_loader (
		.clk_main_a0     (clk_main_a0),
		.rst_main_n_sync (rst_main_n_sync),
		.wready          (wready),
		.wr_addr         (wr_addr),
		.wdata           (wdata),
		.drained         (drained),
		.job             (job),
		.start           (start)
	);

	// 10 rounds, result 11 cycles after start
	aes_round_engine u_engine (
		.clk_main_a0     (clk_main_a0),
		.rst_main_n_sync (rst_main_n_sync),
		.job             (job),
		.start           (start),
		.cipher          (cipher),
		.done            (done)
	);

	// read path, 16 bytes out
	aes_cipher_buffer u_buffer (
		.clk_main_a0     (clk_main_a0),
		.rst_main_n_sync (rst_main_n_sync),
		.cipher          (cipher),
		.done            (done),
		.arvalid_q       (arvalid_q),
		.araddr_q        (araddr_q),
		.rready          (rready),
		.rvalid          (rvalid),
		.rdata           (rdata),
		.drained         (drained)
	);

endmodule

`default_nettype wire

// File: dv/tb_aes_fifo_bridge.sv
//----------------------------------------------------------------------
// self-checking testbench for the aes-128 bridge
// reads key, plaintext and ciphertext from the golden vector file,
// writes each block with decoy writes and random gaps, then reads the
// ciphertext back byte by byte under random rready back-pressure
//----------------------------------------------------------------------
`default_nettype none

module tb_aes_fifo_bridge
	import aes_bridge_pkg::*;
();

	localparam int          NUM_VEC    = 6;
	localparam int          CLK_PERIOD = 40;
	// per vector budget in cycles, 32 writes plus 16 reads plus slack
	localparam int unsigned WATCHDOG_CYCLES = NUM_VEC * (32*8 + 16*12 + 50);

	logic   clk_main_a0;
	logic   rst_main_n_sync;
	logic   wready;
	word_t  wr_addr;
	word_t  wdata;
	logic   arvalid_q;
	word_t  araddr_q;
	logic   rready;
	logic   rvalid;
	word_t  rdata;

	block_t      vec_mem [0:3*NUM_VEC-1];   // key, text, cipher per vector
	logic [31:0] rng_state = 32'h9c7e_381f;

	aes_fifo_bridge UUT (
		.clk_main_a0     (clk_main_a0),
		.rst_main_n_sync (rst_main_n_sync),
		.wready          (wready),
		.wr_addr         (wr_addr),
		.wdata           (wdata),
		.arvalid_q       (arvalid_q),
		.araddr_q        (araddr_q),
		.rready          (rready),
		.rvalid          (rvalid),
		.rdata           (rdata)
	);

	initial
	begin
		clk_main_a0 = 1'b0;
		forever #(CLK_PERIOD/2) clk_main_a0 = ~clk_main_a0;
	end

	//------------------------------------------------------------------
	// random numbers
	//------------------------------------------------------------------
	function automatic logic [31:0] xorshift32(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x = x ^ (x << 13);
		x = x ^ (x >> 17);
		x = x ^ (x << 5);
		return x;
	endfunction

	function automatic logic [31:0] next_word();
		rng_state = xorshift32(rng_state);
		return rng_state;
	endfunction

	function automatic int unsigned pick(input int unsigned n);
		rng_state = xorshift32(rng_state);
		return rng_state % n;   // 0 .. n-1
	endfunction

	// any address but the decoded one
	function automatic word_t other_addr();
		word_t a;
		a = next_word();
		return (a == BRIDGE_DATA_ADDR) ? (a ^ 32'h0000_0004) : a;
	endfunction

	//------------------------------------------------------------------
	// checking and bus tasks
	//------------------------------------------------------------------
	task automatic check(input string name, input word_t expected, input word_t actual);
		if (expected !== actual)
		begin
			$display("FAIL %s expected %h actual %h", name, expected, actual);
			$display("SOME TESTS FAILED");
			$fatal(1, "mismatch in %s", name);
		end
	endtask

	task automatic abort_run(input string why);
		$display("%s", why);
		$display("SOME TESTS FAILED");
		$fatal(1, "run aborted");
	endtask

	// one write strobe, then a random idle gap
	task automatic send_write(input word_t addr, input byte_t data, input logic strobe);
		word_t noise;
		noise   = next_word();
		wready  = strobe;
		wr_addr = addr;
		wdata   = {noise[31:8], data};   // upper bits are don't care for the DUT
		@(negedge clk_main_a0);
		wready  = 1'b0;
		repeat (pick(4)) @(negedge clk_main_a0);
	endtask

	// write that must be ignored, wrong address or wready low
	task automatic send_decoy();
		if (pick(2) == 0)
			send_write(other_addr(), byte_t'(next_word()), 1'b1);
		else
			send_write(BRIDGE_DATA_ADDR, byte_t'(next_word()), 1'b0);
	endtask

	task automatic send_block(input block_t blk);
		block_t rest;
		rest = blk;
		repeat (BLOCK_BYTES)
		begin
			if (pick(4) == 0)
				send_decoy();
			send_write(BRIDGE_DATA_ADDR, rest[127:120], 1'b1);   // byte 0 first
			rest = rest << 8;
		end
	endtask

	// one read request, rready held off for a random number of cycles
	task automatic read_word(input word_t addr, output word_t data);
		word_t held;
		int    waited;
		arvalid_q = 1'b1;
		araddr_q  = addr;
		@(negedge clk_main_a0);
		arvalid_q = 1'b0;
		araddr_q  = other_addr();
		waited    = 0;
		while (!rvalid)
		begin
			waited++;
			if (waited > 20)
				abort_run("read response never arrived");
			else
				@(negedge clk_main_a0);
		end
		held = rdata;
		repeat (pick(5))
		begin
			@(negedge clk_main_a0);
			check("rvalid held under back-pressure", 32'h1, 32'(rvalid));
			check("rdata held under back-pressure", held, rdata);
		end
		rready = 1'b1;
		@(negedge clk_main_a0);
		rready = 1'b0;
		check("rvalid after handshake", 32'h0, 32'(rvalid));
		data = held;
	endtask

	//------------------------------------------------------------------
	// one full vector
	//------------------------------------------------------------------
	task automatic run_vector(input logic [4:0] base, input int v);
		block_t      key;
		block_t      text;
		block_t      ct;
		word_t       got;
		int unsigned polls;
		key  = vec_mem[base];
		text = vec_mem[base + 5'd1];
		ct   = vec_mem[base + 5'd2];
		send_block(key);
		send_block(text);
		// result is still 13 cycles away
		read_word(BRIDGE_DATA_ADDR, got);
		check($sformatf("vec%0d early read", v), 32'h0, got);
		send_write(BRIDGE_DATA_ADDR, byte_t'(next_word()), 1'b1);   // dropped, engine busy
		// poll until the first byte shows up, golden first bytes are nonzero
		polls = 0;
		got   = '0;
		while (got == '0)
		begin
			polls++;
			if (polls > 40)
				abort_run("ciphertext never became readable");
			else
				read_word(BRIDGE_DATA_ADDR, got);
		end
		check($sformatf("vec%0d byte 0", v), {24'h00_0000, ct[127:120]}, got);
		ct = ct << 8;
		for (int i = 1; i < BLOCK_BYTES; i++)
		begin
			if (i == 1 || pick(8) == 0)
			begin
				read_word(other_addr(), got);
				check($sformatf("vec%0d stray read", v), 32'h0, got);
				send_write(BRIDGE_DATA_ADDR, byte_t'(next_word()), 1'b1);   // pending, dropped
			end
			read_word(BRIDGE_DATA_ADDR, got);
			check($sformatf("vec%0d byte %0d", v, i), {24'h00_0000, ct[127:120]}, got);
			ct = ct << 8;
		end
		repeat (3) @(negedge clk_main_a0);   // drained, loader back in LOAD_KEY
	endtask

	//------------------------------------------------------------------
	// main sequence
	//------------------------------------------------------------------
	initial
	begin
		rst_main_n_sync = 1'b0;
		wready          = 1'b0;
		wr_addr         = '0;
		wdata           = '0;
		arvalid_q       = 1'b0;
		araddr_q        = '0;
		rready          = 1'b0;
		$readmemh("dv/aes_golden_vectors.txt", vec_mem);
		if ($isunknown(vec_mem[3*NUM_VEC-1]))
			abort_run("golden vector file is missing or short");
		repeat (8) @(negedge clk_main_a0);
		rst_main_n_sync = 1'b1;
		@(negedge clk_main_a0);
		check("reset rvalid", 32'h0, 32'(rvalid));
		check("reset rdata", 32'h0, rdata);
		for (int v = 0; v < NUM_VEC; v++)
		begin
			run_vector(5'(3*v), v);
		end
		$display("ALL TESTS PASSED");
		$finish;
	end

	// watchdog
	initial
	begin
		#(WATCHDOG_CYCLES * CLK_PERIOD);
		abort_run("timeout, the tests did not finish in time");
	end

endmodule

`default_nettype wire

// File: project.f
rtl/aes_bridge_pkg.sv
rtl/aes_byte_loader.sv
rtl/aes_key_schedule.sv
rtl/aes_round_engine.sv
rtl/aes_cipher_buffer.sv
rtl/aes_fifo_bridge.sv
dv/tb_aes_fifo_bridge.sv

// File: Makefile
# Verilator build for the aes-128 bridge testbench

VERILATOR  = verilator
TOP        = tb_aes_fifo_bridge
FILELIST   = project.f
BUILD_DIR  = obj_dir
LOG        = sim.log
PASS_MSG   = ALL TESTS PASSED
LINT_FLAGS = --lint-only --timing --top-module $(TOP)
SIM_FLAGS  = --binary --timing --top-module $(TOP) --Mdir $(BUILD_DIR)

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FILELIST)

sim:
	$(VERILATOR) $(SIM_FLAGS) -f $(FILELIST)
	./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@grep -q "$(PASS_MSG)" $(LOG) && echo "simulation passed" || \
		(echo "simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// File: dv/aes_golden_vectors.txt
// each line holds key then plaintext then expected ciphertext as 128-bit hex
// byte 0 is leftmost, lines 1 and 2 are the fips-197 appendix b and c.1 examples
2b7e151628aed2a6abf7158809cf4f3c 3243f6a8885a308d313198a2e0370734 3925841d02dc09fbdc118597196a0b32
000102030405060708090a0b0c0d0e0f 00112233445566778899aabbccddeeff 69c4e0d86a7b0430d8cdb78070b4c55a
2b7e151628aed2a6abf7158809cf4f3c 6bc1bee22e409f96e93d7e117393172a 3ad77bb40d7a3660a89ecaf32466ef97
2b7e151628aed2a6abf7158809cf4f3c ae2d8a571e03ac9c9eb76fac45af8e51 f5d3d58503b9699de785895a96fdbaaf
2b7e151628aed2a6abf7158809cf4f3c 30c81c46a35ce411e5fbc1191a0a52ef 43b1cd7f598ece23881b00e3ed030688
2b7e151628aed2a6abf7158809cf4f3c f69f2445df4f9b17ad2b417be66c3710 7b0c785e27e8ad3f8223207104725dd4
